// ==== include/copro_cfg.svh ====
`ifndef COPRO_CFG_SVH
`define COPRO_CFG_SVH

// ====================
// Coprocessor sizing
// ====================

// Word address width of the local memory, which gives 1024 words
`define COPRO_AW 10

// Width of a memory word, a register and an instruction
`define COPRO_DW 32

// Number of general registers in the sequencer
`define COPRO_NREG 8

// Entries in the call/return stack
`define COPRO_STACK_DEPTH 8

// Address the sequencer restarts at after a vsync pulse
`define COPRO_VSYNC_VEC 10'h080

`endif

// ==== src/copro_pkg.sv ====
`include "copro_cfg.svh"

package copro_pkg;

	// ====================
	// Sequencer state
	// ====================

	typedef enum logic [2:0]
	{
		st_ifetch,
		st_decode,
		st_execute,
		st_ip_load,
		st_halt
	} copro_state_t;

	// ====================
	// Instruction format
	// ====================

	// LDI loads the zero-extended imm into rd
	// ADD adds ra into rd
	// JCC tests register rd[2:0] and jumps to imm, rd[3] picks zero (0) or non-zero (1)
	// JMP sub-operation in rd: 0 jump, 1 call, 2 return
	// WAIT waits for a host write to address imm
	// JMPI reads the new instruction pointer from the word at address imm
	// OUT sends rd to the output port
	typedef enum logic [3:0]
	{
		OP_NOP  = 4'h0,
		OP_LDI  = 4'h1,
		OP_ADD  = 4'h2,
		OP_JCC  = 4'h3,
		OP_JMP  = 4'h4,
		OP_WAIT = 4'h5,
		OP_JMPI = 4'h6,
		OP_OUT  = 4'h7,
		OP_HALT = 4'h8
	} copro_opcode_t;

	// Opcode sits in the top nibble, imm in the low half-word
	typedef struct packed
	{
		copro_opcode_t opcode;
		logic [3:0] rd;
		logic [3:0] ra;
		logic [3:0] pad;
		logic [15:0] imm;
	} copro_instruction_t;

	// ====================
	// Local memory port
	// ====================

	typedef struct packed
	{
		logic valid;
		logic we;
		logic [`COPRO_AW-1:0] adr;
		logic [`COPRO_DW-1:0] dat;
	} mem_req_t;

	typedef struct packed
	{
		logic ack;
		logic [`COPRO_DW-1:0] dat;
	} mem_resp_t;

	// One write seen by the arbiter, used to end a WAIT
	typedef struct packed
	{
		logic valid;
		logic [`COPRO_AW-1:0] adr;
	} wr_snoop_t;

endpackage

// ==== src/copro_next_ip.sv ====
`timescale 1ns/1ps
`include "copro_cfg.svh"

module copro_next_ip
(
	input logic rst,
	input copro_pkg::copro_state_t state,
	input copro_pkg::copro_instruction_t ir,
	input logic [`COPRO_AW-1:0] ip,
	input logic [`COPRO_DW-1:0] ra_val,
	input logic [`COPRO_DW-1:0] rd_val,
	input logic [`COPRO_AW-1:0] stack_top,
	input logic vsync_pend,
	input logic adr_hit,
	input copro_pkg::mem_resp_t resp,
	output logic [`COPRO_AW-1:0] next_ip
);

	logic [`COPRO_DW-1:0] imm_sext;
	logic [`COPRO_DW-1:0] jmp_target;
	logic take_jcc;

	// Relative jumps and calls use a signed 16-bit offset from ra
	assign imm_sext = {{(`COPRO_DW-16){ir.imm[15]}}, ir.imm};
	assign jmp_target = ra_val + imm_sext;

	// Condition bit 3 of rd flips the test from zero to non-zero
	assign take_jcc = ir.rd[3] ? (rd_val != '0) : (rd_val == '0);

	always_comb
	begin
		// Hold the pointer unless a state below says otherwise
		next_ip = ip;
		if (rst)
			next_ip = '0;
		else
		begin
			case (state)
			copro_pkg::st_ifetch:
				// The fetched word is thrown away when a vsync is taken
				if (resp.ack)
				begin
					if (vsync_pend)
						next_ip = `COPRO_VSYNC_VEC;
					else
						next_ip = ip + 1'b1;
				end
			copro_pkg::st_execute:
				case (ir.opcode)
				copro_pkg::OP_WAIT:
					// Stay on the following instruction until the write shows up
					if (!adr_hit)
						next_ip = ip;
				copro_pkg::OP_JCC:
					if (take_jcc)
						next_ip = ir.imm[`COPRO_AW-1:0];
				copro_pkg::OP_JMP:
					case (ir.rd)
					4'd0:
						next_ip = jmp_target[`COPRO_AW-1:0];
					4'd1:
						next_ip = jmp_target[`COPRO_AW-1:0];
					4'd2:
						next_ip = stack_top;
					default:
						next_ip = ip;
					endcase
				default:
					next_ip = ip;
				endcase
			copro_pkg::st_ip_load:
				// Memory word holds the target in its low bits
				if (resp.ack)
					next_ip = resp.dat[`COPRO_AW-1:0];
			default:
				next_ip = ip;
			endcase
		end
	end

endmodule

// ==== src/copro_seq.sv ====
`timescale 1ns/1ps
`include "copro_cfg.svh"

module copro_seq
(
	input logic clk,
	input logic rst,
	input logic run,
	input logic vsync,
	input copro_pkg::mem_resp_t seq_resp,
	input copro_pkg::wr_snoop_t wr_snoop,
	input logic [`COPRO_AW-1:0] next_ip,
	output copro_pkg::mem_req_t seq_req,
	output copro_pkg::copro_state_t state,
	output copro_pkg::copro_instruction_t ir,
	output logic [`COPRO_AW-1:0] ip,
	output logic [`COPRO_DW-1:0] ra_val,
	output logic [`COPRO_DW-1:0] rd_val,
	output logic [`COPRO_AW-1:0] stack_top,
	output logic vsync_pend,
	output logic adr_hit,
	output logic out_valid,
	output logic [`COPRO_DW-1:0] out_dat
);

	localparam int RW = $clog2(`COPRO_NREG);
	localparam int SW = $clog2(`COPRO_STACK_DEPTH);

	logic [`COPRO_DW-1:0] regs [`COPRO_NREG];
	logic [`COPRO_AW-1:0] stack [`COPRO_STACK_DEPTH];
	logic [SW-1:0] sp;
	logic [SW-1:0] sp_dec;
	logic req_valid;
	logic vsync_take;
	logic snoop_match;

	// ====================
	// Memory request
	// ====================

	// Only reads leave the sequencer, the JMPI word address comes from imm
	always_comb
	begin
		seq_req.valid = req_valid;
		seq_req.we = 1'b0;
		seq_req.adr = (state == copro_pkg::st_ip_load) ? ir.imm[`COPRO_AW-1:0] : ip;
		seq_req.dat = '0;
	end

	// A pending vsync is taken when a fetch completes
	assign vsync_take = (state == copro_pkg::st_ifetch) && seq_resp.ack && vsync_pend;

	// ====================
	// State machine
	// ====================

	always_ff @(posedge clk)
	if (rst)
	begin
		state <= copro_pkg::st_halt;
		ir <= '0;
		req_valid <= 1'b0;
	end
	else
	begin
		case (state)
		copro_pkg::st_halt:
			// After HALT only a vsync starts the sequencer again
			if (run && (ir.opcode != copro_pkg::OP_HALT || vsync_pend))
				state <= copro_pkg::st_ifetch;
		copro_pkg::st_ifetch:
			if (seq_resp.ack)
			begin
				req_valid <= 1'b0;
				// With a vsync pending the word is dropped and the vector fetched next
				if (!vsync_pend)
				begin
					ir <= copro_pkg::copro_instruction_t'(seq_resp.dat);
					state <= copro_pkg::st_decode;
				end
			end
			else if (!req_valid && run)
				req_valid <= 1'b1;
		copro_pkg::st_decode:
			state <= copro_pkg::st_execute;
		copro_pkg::st_execute:
			case (ir.opcode)
			copro_pkg::OP_WAIT:
				if (adr_hit)
					state <= copro_pkg::st_ifetch;
			copro_pkg::OP_JMPI:
				state <= copro_pkg::st_ip_load;
			copro_pkg::OP_HALT:
				state <= copro_pkg::st_halt;
			default:
				state <= copro_pkg::st_ifetch;
			endcase
		copro_pkg::st_ip_load:
			if (seq_resp.ack)
			begin
				req_valid <= 1'b0;
				state <= copro_pkg::st_ifetch;
			end
			else if (!req_valid)
				req_valid <= 1'b1;
		default:
			state <= copro_pkg::st_halt;
		endcase
	end

	// Pointer is chosen outside, reset comes through next_ip
	always_ff @(posedge clk)
		ip <= next_ip;

	// ====================
	// Registers and stack
	// ====================

	// Operands are read in decode so execute works from stable values
	always_ff @(posedge clk)
	if (state == copro_pkg::st_decode)
	begin
		ra_val <= regs[ir.ra[RW-1:0]];
		rd_val <= regs[ir.rd[RW-1:0]];
	end

	always_ff @(posedge clk)
	if (rst)
	begin
		for (int i = 0; i < `COPRO_NREG; i++)
			regs[i] <= '0;
		sp <= '0;
	end
	else if (state == copro_pkg::st_execute)
	begin
		case (ir.opcode)
		copro_pkg::OP_LDI:
			regs[ir.rd[RW-1:0]] <= {{(`COPRO_DW-16){1'b0}}, ir.imm};
		copro_pkg::OP_ADD:
			regs[ir.rd[RW-1:0]] <= rd_val + ra_val;
		copro_pkg::OP_JMP:
			// ip already points past the call, so it is the return address
			if (ir.rd == 4'd1)
			begin
				stack[sp] <= ip;
				sp <= sp + 1'b1;
			end
			else if (ir.rd == 4'd2)
				sp <= sp_dec;
		default:
			sp <= sp;
		endcase
	end

	// Stack pointer addresses the next free slot
	assign sp_dec = sp - 1'b1;
	assign stack_top = stack[sp_dec];

	// ====================
	// Vsync and write watch
	// ====================

	assign snoop_match = wr_snoop.valid && (ir.opcode == copro_pkg::OP_WAIT)
		&& (wr_snoop.adr == ir.imm[`COPRO_AW-1:0]);

	always_ff @(posedge clk)
	if (rst)
	begin
		vsync_pend <= 1'b0;
		adr_hit <= 1'b0;
	end
	else
	begin
		// A new pulse in the take cycle stays pending
		vsync_pend <= vsync | (vsync_pend & ~vsync_take);
		case (state)
		copro_pkg::st_decode:
			adr_hit <= snoop_match;
		copro_pkg::st_execute:
			adr_hit <= adr_hit | snoop_match;
		default:
			adr_hit <= 1'b0;
		endcase
	end

	// Output strobe is the execute cycle of OUT itself
	assign out_valid = (state == copro_pkg::st_execute) && (ir.opcode == copro_pkg::OP_OUT);
	assign out_dat = rd_val;

endmodule

// ==== src/copro_mem_arb.sv ====
`timescale 1ns/1ps

module copro_mem_arb
(
	input logic clk,
	input logic rst,
	input copro_pkg::mem_req_t host_req,
	input copro_pkg::mem_req_t seq_req,
	output copro_pkg::mem_resp_t host_resp,
	output copro_pkg::mem_resp_t seq_resp,
	output copro_pkg::mem_req_t mem_req,
	input copro_pkg::mem_resp_t mem_resp,
	output copro_pkg::wr_snoop_t wr_snoop
);

	logic busy;
	logic own_host;
	logic req_valid;
	logic grant_host;
	logic grant_seq;
	copro_pkg::mem_req_t req_q;

	// Host wins a tie, nobody is granted while an access is open
	assign grant_host = !busy && host_req.valid;
	assign grant_seq = !busy && !host_req.valid && seq_req.valid;

	// ====================
	// Grant and owner
	// ====================

	// Busy drops after the ack cycle so that cycle never grants
	always_ff @(posedge clk)
	if (rst)
	begin
		busy <= 1'b0;
		own_host <= 1'b0;
		req_valid <= 1'b0;
	end
	else
	begin
		req_valid <= grant_host | grant_seq;
		if (grant_host | grant_seq)
		begin
			busy <= 1'b1;
			own_host <= grant_host;
		end
		else if (mem_resp.ack)
			busy <= 1'b0;
	end

	// Granted request is held for the memory cycle
	always_ff @(posedge clk)
	if (grant_host)
		req_q <= host_req;
	else if (grant_seq)
		req_q <= seq_req;

	always_comb
	begin
		mem_req.valid = req_valid;
		mem_req.we = req_q.we;
		mem_req.adr = req_q.adr;
		mem_req.dat = req_q.dat;
	end

	// ====================
	// Response steering
	// ====================

	assign host_resp.ack = mem_resp.ack & own_host;
	assign host_resp.dat = mem_resp.dat;
	assign seq_resp.ack = mem_resp.ack & ~own_host;
	assign seq_resp.dat = mem_resp.dat;

	// Writes are reported in the cycle they reach the memory
	assign wr_snoop.valid = req_valid & req_q.we;
	assign wr_snoop.adr = req_q.adr;

endmodule

// ==== src/copro_local_mem.sv ====
`timescale 1ns/1ps
`include "copro_cfg.svh"

module copro_local_mem
(
	input logic clk,
	input logic rst,
	input copro_pkg::mem_req_t mem_req,
	output copro_pkg::mem_resp_t mem_resp
);

	localparam int DEPTH = 1 << `COPRO_AW;

	logic [`COPRO_DW-1:0] mem [DEPTH];
	logic [`COPRO_DW-1:0] dat_q;
	logic ack_q;

	// Single port, a write and a read never share a cycle
	always_ff @(posedge clk)
	if (mem_req.valid && mem_req.we)
		mem[mem_req.adr] <= mem_req.dat;

	// Read data is registered and lines up with the ack
	always_ff @(posedge clk)
		dat_q <= mem[mem_req.adr];

	// Every access is acknowledged one cycle later, writes too
	always_ff @(posedge clk)
	if (rst)
		ack_q <= 1'b0;
	else
		ack_q <= mem_req.valid;

	assign mem_resp.ack = ack_q;
	assign mem_resp.dat = dat_q;

endmodule

// ==== src/copro_top.sv ====
`timescale 1ns/1ps
`include "copro_cfg.svh"

module copro_top
(
	input logic clk,
	input logic rst,
	input copro_pkg::mem_req_t host_req,
	output copro_pkg::mem_resp_t host_resp,
	input logic vsync,
	input logic run,
	output logic out_valid,
	output logic [`COPRO_DW-1:0] out_dat
);

	copro_pkg::mem_req_t seq_req;
	copro_pkg::mem_resp_t seq_resp;
	copro_pkg::mem_req_t mem_req;
	copro_pkg::mem_resp_t mem_resp;
	copro_pkg::wr_snoop_t wr_snoop;
	copro_pkg::copro_state_t state;
	copro_pkg::copro_instruction_t ir;
	logic [`COPRO_AW-1:0] ip;
	logic [`COPRO_AW-1:0] next_ip;
	logic [`COPRO_AW-1:0] stack_top;
	logic [`COPRO_DW-1:0] ra_val;
	logic [`COPRO_DW-1:0] rd_val;
	logic vsync_pend;
	logic adr_hit;

	// ====================
	// Sequencer side
	// ====================

	copro_seq seq_i
	(
		.clk(clk),
		.rst(rst),
		.run(run),
		.vsync(vsync),
		.seq_resp(seq_resp),
		.wr_snoop(wr_snoop),
		.next_ip(next_ip),
		.seq_req(seq_req),
		.state(state),
		.ir(ir),
		.ip(ip),
		.ra_val(ra_val),
		.rd_val(rd_val),
		.stack_top(stack_top),
		.vsync_pend(vsync_pend),
		.adr_hit(adr_hit),
		.out_valid(out_valid),
		.out_dat(out_dat)
	);

	// Next pointer sees the sequencer response directly
	copro_next_ip next_ip_i
	(
		.rst(rst),
		.state(state),
		.ir(ir),
		.ip(ip),
		.ra_val(ra_val),
		.rd_val(rd_val),
		.stack_top(stack_top),
		.vsync_pend(vsync_pend),
		.adr_hit(adr_hit),
		.resp(seq_resp),
		.next_ip(next_ip)
	);

	// ====================
	// Shared memory
	// ====================

	copro_mem_arb arb_i
	(
		.clk(clk),
		.rst(rst),
		.host_req(host_req),
		.seq_req(seq_req),
		.host_resp(host_resp),
		.seq_resp(seq_resp),
		.mem_req(mem_req),
		.mem_resp(mem_resp),
		.wr_snoop(wr_snoop)
	);

	copro_local_mem mem_i
	(
		.clk(clk),
		.rst(rst),
		.mem_req(mem_req),
		.mem_resp(mem_resp)
	);

endmodule

// ==== tests/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen
#(
	parameter int PERIOD = 4,
	parameter int RESET_CYCLES = 4
)
(
	output logic clk,
	output logic rst
);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD / 2) clk = ~clk;
	end

	// Reset drops just after an edge, like every other driven input
	initial
	begin
		rst = 1'b1;
		repeat (RESET_CYCLES)
			@(posedge clk);
		#1 rst = 1'b0;
	end

endmodule

// ==== tests/copro_sva.sv ====
`timescale 1ns/1ps

module copro_sva
(
	input logic clk,
	input logic rst,
	input copro_pkg::mem_req_t host_req,
	input copro_pkg::mem_req_t seq_req,
	input copro_pkg::mem_resp_t host_resp,
	input copro_pkg::mem_resp_t seq_resp,
	input logic out_valid
);

	// ====================
	// Handshake rules
	// ====================

	host_ack_pulse: assert property (@(posedge clk) disable iff (rst)
		host_resp.ack |=> !host_resp.ack)
		else $error("host ack lasted more than one cycle");

	seq_ack_pulse: assert property (@(posedge clk) disable iff (rst)
		seq_resp.ack |=> !seq_resp.ack)
		else $error("sequencer ack lasted more than one cycle");

	// Once raised, a request stays up until its ack cycle
	host_req_held: assert property (@(posedge clk) disable iff (rst)
		host_req.valid && !host_resp.ack |=> host_req.valid)
		else $error("host request dropped before ack");

	seq_req_held: assert property (@(posedge clk) disable iff (rst)
		seq_req.valid && !seq_resp.ack |=> seq_req.valid)
		else $error("sequencer request dropped before ack");

	out_single: assert property (@(posedge clk) disable iff (rst)
		out_valid |=> !out_valid)
		else $error("out_valid high in two adjacent cycles");

	// The first reset edge still sees power-up values, so check from the second
	quiet_in_reset: assert property (@(posedge clk)
		rst && $past(rst) |-> !out_valid && !host_resp.ack && !seq_req.valid)
		else $error("activity seen while in reset");

endmodule

bind copro_top copro_sva sva_i
(
	.clk(clk),
	.rst(rst),
	.host_req(host_req),
	.seq_req(seq_req),
	.host_resp(host_resp),
	.seq_resp(seq_resp),
	.out_valid(out_valid)
);

// ==== tests/copro_tb.sv ====
`timescale 1ns/1ps
`include "copro_cfg.svh"

module copro_tb;

	localparam int CLK_PERIOD = 4;
	localparam int MEM_WORDS = 24;
	localparam int N_STRAIGHT = 4;
	localparam int STRAIGHT_LEN = 16;
	localparam int N_FLOW = 4;
	localparam int FLOW_LEN = 20;
	localparam int SUB_LEN = 4;
	// Host accesses and program loads count like instructions for the budget
	localparam int TOTAL_INSTR = 2 * MEM_WORDS + N_STRAIGHT * 2 * STRAIGHT_LEN
		+ N_FLOW * 2 * (FLOW_LEN + SUB_LEN) + 3 * 16 + 40;
	localparam int WATCHDOG_CYCLES = TOTAL_INSTR * 20;
	localparam logic [`COPRO_AW-1:0] VEC = `COPRO_VSYNC_VEC;

	logic clk;
	logic rst;
	copro_pkg::mem_req_t host_req;
	copro_pkg::mem_resp_t host_resp;
	logic vsync;
	logic run;
	logic out_valid;
	logic [`COPRO_DW-1:0] out_dat;

	int seed;
	int errors;
	int test_errs;
	int pass_cnt;
	int fail_cnt;

	// Reference state of the instruction-set model
	logic [`COPRO_DW-1:0] mm [1 << `COPRO_AW];
	logic [`COPRO_DW-1:0] mregs [8];
	logic [`COPRO_AW-1:0] mstack [8];
	logic [2:0] msp;
	logic [`COPRO_DW-1:0] exp_q [$];
	logic [`COPRO_DW-1:0] got_q [$];

	tb_clkgen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(4)) clkgen_i
	(
		.clk(clk),
		.rst(rst)
	);

	copro_top dut_i
	(
		.clk(clk),
		.rst(rst),
		.host_req(host_req),
		.host_resp(host_resp),
		.vsync(vsync),
		.run(run),
		.out_valid(out_valid),
		.out_dat(out_dat)
	);

	// Output port is sampled mid-cycle where it is stable
	always @(negedge clk)
		if (!rst && out_valid)
			got_q.push_back(out_dat);

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

	// ====================
	// Helpers
	// ====================

	function automatic int unsigned pick(input int unsigned n);
		pick = $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [31:0] enc(input logic [3:0] op, input logic [3:0] rd,
		input logic [3:0] ra, input logic [15:0] imm);
		enc = {op, rd, ra, 4'h0, imm};
	endfunction

	// Runs the program from start and lists the OUT values it should produce
	function automatic void model_run(input logic [`COPRO_AW-1:0] start);
		logic [`COPRO_AW-1:0] ip;
		logic [31:0] w;
		logic [3:0] op;
		logic [3:0] rd;
		logic [3:0] ra;
		logic [15:0] imm;
		logic [31:0] v;
		logic [31:0] tgt;
		int steps;
		bit done;
		ip = start;
		done = 1'b0;
		steps = 0;
		exp_q.delete();
		while (!done && steps < 1000)
		begin
			w = mm[ip];
			ip = ip + 10'd1;
			op = w[31:28];
			rd = w[27:24];
			ra = w[23:20];
			imm = w[15:0];
			steps++;
			tgt = mregs[ra[2:0]] + {{16{imm[15]}}, imm};
			case (op)
			4'h1: mregs[rd[2:0]] = {16'h0, imm};
			4'h2: mregs[rd[2:0]] = mregs[rd[2:0]] + mregs[ra[2:0]];
			4'h3:
			begin
				v = mregs[rd[2:0]];
				if (rd[3] ? (v != 0) : (v == 0))
					ip = imm[`COPRO_AW-1:0];
			end
			4'h4:
				if (rd == 4'd0)
					ip = tgt[`COPRO_AW-1:0];
				else if (rd == 4'd1)
				begin
					mstack[msp] = ip;
					msp = msp + 3'd1;
					ip = tgt[`COPRO_AW-1:0];
				end
				else if (rd == 4'd2)
				begin
					msp = msp - 3'd1;
					ip = mstack[msp];
				end
			4'h6: ip = mm[imm[`COPRO_AW-1:0]][`COPRO_AW-1:0];
			4'h7: exp_q.push_back(mregs[rd[2:0]]);
			4'h8: done = 1'b1;
			default: ;
			endcase
		end
	endfunction

	task automatic note_error();
		errors++;
		test_errs++;
	endtask

	task automatic check_word(input string name, input copro_pkg::mem_resp_t got,
		input copro_pkg::mem_resp_t exp);
		if (got !== exp)
		begin
			$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
			note_error();
		end
	endtask

	task automatic check_out(input string name, input logic [`COPRO_DW-1:0] got,
		input logic [`COPRO_DW-1:0] exp);
		if (got !== exp)
		begin
			$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
			note_error();
		end
	endtask

	// Drives one host access and keeps the request up through the ack cycle
	task automatic host_access(input logic we, input logic [`COPRO_AW-1:0] adr,
		input logic [`COPRO_DW-1:0] dat, output copro_pkg::mem_resp_t resp);
		int n;
		@(posedge clk);
		#1;
		host_req.valid = 1'b1;
		host_req.we = we;
		host_req.adr = adr;
		host_req.dat = dat;
		n = 0;
		do
		begin
			@(posedge clk);
			#1;
			n++;
		end
		while (!host_resp.ack && n < 50);
		resp = host_resp;
		// The request is released only after the edge that closes the ack cycle
		if (resp.ack)
		begin
			@(posedge clk);
			#1;
		end
		host_req.valid = 1'b0;
		host_req.we = 1'b0;
		if (!resp.ack)
		begin
			$display("host access to address 0x%h was never acknowledged", adr);
			note_error();
		end
	endtask

	task automatic load_word(input logic [`COPRO_AW-1:0] adr, input logic [31:0] dat);
		copro_pkg::mem_resp_t resp;
		host_access(1'b1, adr, dat, resp);
		mm[adr] = dat;
	endtask

	task automatic wait_state(input bit want_halt, input int limit, output bit ok);
		int n;
		ok = 1'b0;
		n = 0;
		while (!ok && n < limit)
		begin
			@(posedge clk);
			#1;
			n++;
			if ((dut_i.seq_i.state == copro_pkg::st_halt) == want_halt)
				ok = 1'b1;
		end
	endtask

	task automatic pulse_vsync();
		@(posedge clk);
		#1 vsync = 1'b1;
		@(posedge clk);
		#1 vsync = 1'b0;
	endtask

	task automatic wait_halted(input int limit);
		bit ok;
		wait_state(1'b0, 20, ok);
		if (!ok)
		begin
			$display("sequencer never left halt");
			note_error();
		end
		wait_state(1'b1, limit, ok);
		if (!ok)
		begin
			$display("program did not reach HALT within %0d cycles", limit);
			note_error();
		end
	endtask

	task automatic compare_outs();
		int n;
		if (got_q.size() != exp_q.size())
		begin
			$display("%0d OUT values seen where %0d were expected", got_q.size(), exp_q.size());
			note_error();
		end
		n = (got_q.size() < exp_q.size()) ? got_q.size() : exp_q.size();
		for (int i = 0; i < n; i++)
			check_out($sformatf("out_dat[%0d]", i), got_q[i], exp_q[i]);
	endtask

	// Starts the program at the vector through vsync and checks its outputs
	task automatic run_loaded(input int len);
		model_run(VEC);
		got_q.delete();
		pulse_vsync();
		wait_halted(len * 20 + 40);
		compare_outs();
	endtask

	task automatic end_test(input string name);
		if (test_errs == 0)
		begin
			pass_cnt++;
			$display("test %s: passed", name);
		end
		else
		begin
			fail_cnt++;
			$display("test %s: failed with %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	// ====================
	// Program generators
	// ====================

	// r7 is never written, so jumps through it are absolute
	function automatic logic [31:0] rand_alu();
		case (pick(3))
		0: rand_alu = enc(4'h1, 4'(pick(7)), 4'h0, 16'(pick(65536)));
		1: rand_alu = enc(4'h2, 4'(pick(7)), 4'(pick(7)), 16'h0);
		default: rand_alu = enc(4'h7, 4'(pick(7)), 4'h0, 16'h0);
		endcase
	endfunction

	task automatic gen_straight(input int len);
		for (int i = 0; i < len - 1; i++)
			load_word(10'(VEC + i), rand_alu());
		load_word(10'(VEC + len - 1), enc(4'h8, 4'h0, 4'h0, 16'h0));
	endtask

	// Main body ends in HALT, the subroutine behind it ends in RET
	task automatic gen_flow(input int len, input int sub);
		logic [31:0] w;
		int tgt;
		for (int i = 0; i < len - 1; i++)
		begin
			tgt = i + 1 + pick(3);
			if (tgt > len - 1)
				tgt = len - 1;
			case (pick(6))
			3: w = enc(4'h3, 4'(pick(2) * 8 + pick(7)), 4'h0, 16'(VEC + tgt));
			4: w = enc(4'h4, 4'h0, 4'h7, 16'(VEC + tgt));
			5: w = enc(4'h4, 4'h1, 4'h7, 16'(VEC + len));
			default: w = rand_alu();
			endcase
			load_word(10'(VEC + i), w);
		end
		load_word(10'(VEC + len - 1), enc(4'h8, 4'h0, 4'h0, 16'h0));
		for (int i = 0; i < sub - 1; i++)
			load_word(10'(VEC + len + i), rand_alu());
		load_word(10'(VEC + len + sub - 1), enc(4'h4, 4'h2, 4'h0, 16'h0));
	endtask

	// ====================
	// Test sequence
	// ====================

	initial
	begin
		logic [`COPRO_AW-1:0] adrs [$];
		logic [`COPRO_AW-1:0] adr;
		logic [`COPRO_AW-1:0] tgt;
		logic [15:0] val;
		copro_pkg::mem_resp_t resp;
		copro_pkg::mem_resp_t exp;
		int n;
		seed = 76;
		host_req = '0;
		vsync = 1'b0;
		run = 1'b0;
		errors = 0;
		test_errs = 0;
		pass_cnt = 0;
		fail_cnt = 0;
		msp = 3'd0;
		for (int i = 0; i < 8; i++)
			mregs[i] = '0;
		wait (rst == 1'b0);

		// Boot into a HALT at address 0, later programs start by vsync
		load_word(10'h000, enc(4'h8, 4'h0, 4'h0, 16'h0));
		run = 1'b1;
		wait_halted(100);
		end_test("boot");

		for (int i = 0; i < MEM_WORDS; i++)
		begin
			adr = 10'(pick(1 << `COPRO_AW));
			load_word(adr, $random(seed));
			adrs.push_back(adr);
		end
		foreach (adrs[i])
		begin
			host_access(1'b0, adrs[i], '0, resp);
			exp.ack = 1'b1;
			exp.dat = mm[adrs[i]];
			check_word("host_resp", resp, exp);
		end
		end_test("host write and read");

		for (int k = 0; k < N_STRAIGHT; k++)
		begin
			gen_straight(STRAIGHT_LEN);
			run_loaded(STRAIGHT_LEN);
			end_test($sformatf("straight program %0d", k));
		end

		for (int k = 0; k < N_FLOW; k++)
		begin
			gen_flow(FLOW_LEN, SUB_LEN);
			run_loaded(FLOW_LEN + SUB_LEN);
			end_test($sformatf("branch program %0d", k));
		end

		// WAIT must hold until the host writes the watched word
		adr = 10'(10'h200 + pick(256));
		load_word(VEC, enc(4'h1, 4'h1, 4'h0, 16'(pick(65536))));
		load_word(VEC + 10'd1, enc(4'h7, 4'h1, 4'h0, 16'h0));
		load_word(VEC + 10'd2, enc(4'h5, 4'h0, 4'h0, {6'h0, adr}));
		load_word(VEC + 10'd3, enc(4'h1, 4'h2, 4'h0, 16'(pick(65536))));
		load_word(VEC + 10'd4, enc(4'h7, 4'h2, 4'h0, 16'h0));
		load_word(VEC + 10'd5, enc(4'h8, 4'h0, 4'h0, 16'h0));
		model_run(VEC);
		got_q.delete();
		pulse_vsync();
		n = 0;
		while (got_q.size() < 1 && n < 200)
		begin
			@(posedge clk);
			n++;
		end
		repeat (40)
			@(posedge clk);
		if (got_q.size() != 1)
		begin
			$display("expected one OUT before the WAIT write, saw %0d", got_q.size());
			note_error();
		end
		load_word(adr, $random(seed));
		wait_state(1'b1, 200, resp.ack);
		if (!resp.ack)
		begin
			$display("program did not halt after the WAIT address was written");
			note_error();
		end
		compare_outs();
		end_test("wait on host write");

		// JMPI takes its target from a pointer word, the fall-through path is skipped
		adr = 10'(10'h300 + pick(128));
		tgt = 10'(10'h100 + pick(128));
		val = 16'(pick(65536));
		load_word(adr, {22'(pick(1 << 22)), tgt});
		load_word(VEC, enc(4'h6, 4'h0, 4'h0, {6'h0, adr}));
		load_word(VEC + 10'd1, enc(4'h1, 4'h1, 4'h0, 16'hdead));
		load_word(VEC + 10'd2, enc(4'h7, 4'h1, 4'h0, 16'h0));
		load_word(VEC + 10'd3, enc(4'h8, 4'h0, 4'h0, 16'h0));
		load_word(tgt, enc(4'h1, 4'h3, 4'h0, val));
		load_word(tgt + 10'd1, enc(4'h7, 4'h3, 4'h0, 16'h0));
		load_word(tgt + 10'd2, enc(4'h8, 4'h0, 4'h0, 16'h0));
		run_loaded(8);
		end_test("indirect jump");

		load_word(VEC, enc(4'h1, 4'h4, 4'h0, 16'(pick(65536))));
		load_word(VEC + 10'd1, enc(4'h7, 4'h4, 4'h0, 16'h0));
		load_word(VEC + 10'd2, enc(4'h1, 4'h5, 4'h0, 16'(pick(65536))));
		load_word(VEC + 10'd3, enc(4'h7, 4'h5, 4'h0, 16'h0));
		load_word(VEC + 10'd4, enc(4'h8, 4'h0, 4'h0, 16'h0));
		run_loaded(5);
		end_test("vsync restart");

		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0 && errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+include
src/copro_pkg.sv
src/copro_next_ip.sv
src/copro_seq.sv
src/copro_mem_arb.sv
src/copro_local_mem.sv
src/copro_top.sv
tests/tb_clkgen.sv
tests/copro_sva.sv
tests/copro_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the coprocessor testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module copro_tb --Mdir obj_dir -o copro_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/copro_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "TEST RESULT: PASS" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1
